//--- Makefile
VERILATOR := verilator
VFLAGS    := --timing
TOP       := wb_tb
FILELIST  := sources.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := TESTS PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(BUILD_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || (echo "Simulation failed, see $(LOG)" && exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- bench/wb_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "wb_consts.svh"

module wb_tb
  import wb_pkg::*;
();

  localparam int CLK_PERIOD = 4;
  localparam int NUM_TESTS  = 6;

  logic                      clk;
  logic                      arst_n_i;
  logic                      stall_i;
  logic                      instr_valid_i;
  logic [`WB_RES_SEL_W-1:0]  res_src_i;
  logic [`WB_INSTR_W-1:0]    instr_i;
  logic [`WB_XLEN-1:0]       alu_result_i;
  logic [`WB_XLEN-1:0]       ld_data_i;
  logic [`WB_XLEN-1:0]       pc_plus4_i;
  logic [`WB_XLEN-1:0]       jb_tgt_i;
  logic [`WB_XLEN-1:0]       csr_rdata_i;
  logic [`WB_XLEN-1:0]       div_result_i;
  logic [`WB_FUNCT3_W-1:0]   funct3_i;
  logic [`WB_XLEN-1:0]       rs1_data_i;
  logic [`WB_XLEN-1:0]       rs2_data_i;
  logic [`WB_PROD_W-1:0]     product_i;
  logic                      trap_i;
  logic [`WB_TRAP_W-1:0]     trap_code_i;
  logic                      is_ebreak_i;
  logic                      reg_write_i;
  logic                      is_fp_load_i;
  logic                      fp_reg_write_i;
  logic [`WB_REG_ADDR_W-1:0] fp_rd_i;
  logic [`WB_XLEN-1:0]       fp_result_i;
  logic [`WB_FFLAGS_W-1:0]   fflags_i;
  logic [`WB_XLEN-1:0]       rd_data_o;
  logic [`WB_XLEN-1:0]       fp_rd_data_o;
  logic [`WB_REG_ADDR_W-1:0] fp_rd_addr_o;
  logic                      fp_rd_en_o;
  logic [`WB_FFLAGS_W-1:0]   fflags_set_o;
  logic                      fflags_set_en_o;
  logic                      ret_valid_o;
  logic [`WB_INSTR_W-1:0]    ret_instr_o;
  logic [`WB_XLEN-1:0]       ret_pc_o;
  logic [`WB_XLEN-1:0]       ret_rs1_data_o;
  logic [`WB_XLEN-1:0]       ret_rs2_data_o;
  logic [`WB_XLEN-1:0]       ret_rd_data_o;
  logic                      ret_trap_o;
  logic [`WB_TRAP_W-1:0]     ret_trap_code_o;
  logic                      ret_reg_write_o;
  logic                      ret_ebreak_o;

  int          test_errors;
  int          tests_passed;
  int          tests_failed;
  int unsigned seed_init;

  wb_top uut (.*);

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Signed products are formed at full width, then split into words
  function automatic logic [31:0] mul_model(input logic [1:0] op, input logic [31:0] a,
                                            input logic [31:0] b);
    logic signed [63:0] ss;
    logic signed [63:0] su;
    logic [63:0]        uu;
    ss = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
    su = $signed({{32{a[31]}}, a}) * $signed({32'd0, b});
    uu = {32'd0, a} * {32'd0, b};
    case (op)
      2'd0:    return ss[31:0];
      2'd1:    return ss[63:32];
      2'd2:    return su[63:32];
      default: return uu[63:32];
    endcase
  endfunction

  function automatic logic [31:0] expected_rd();
    case (res_src_i)
      3'd0:    return alu_result_i;
      3'd1:    return ld_data_i;
      3'd2:    return pc_plus4_i;
      3'd3:    return jb_tgt_i;
      3'd4:    return csr_rdata_i;
      3'd5:    return funct3_i[2] ? div_result_i :
                      mul_model(funct3_i[1:0], rs1_data_i, rs2_data_i);
      default: return 32'd0;
    endcase
  endfunction

  task automatic compare(input string name, input string what, input logic [31:0] exp_val,
                         input logic [31:0] act_val);
    if (act_val !== exp_val) begin
      $display("** Error %s: %s expected %h, actual %h", name, what, exp_val, act_val);
      test_errors++;
    end
  endtask

  task automatic finish_test(input string name);
    if (test_errors == 0) begin
      $display("%s: ok", name);
      tests_passed++;
    end else begin
      $display("%s: %0d mismatches", name, test_errors);
      tests_failed++;
    end
    test_errors = 0;
  endtask

  task automatic drive_idle();
    stall_i        = 1'b0;
    instr_valid_i  = 1'b0;
    res_src_i      = '0;
    instr_i        = '0;
    alu_result_i   = '0;
    ld_data_i      = '0;
    pc_plus4_i     = '0;
    jb_tgt_i       = '0;
    csr_rdata_i    = '0;
    div_result_i   = '0;
    funct3_i       = '0;
    rs1_data_i     = '0;
    rs2_data_i     = '0;
    product_i      = '0;
    trap_i         = 1'b0;
    trap_code_i    = '0;
    is_ebreak_i    = 1'b0;
    reg_write_i    = 1'b0;
    is_fp_load_i   = 1'b0;
    fp_reg_write_i = 1'b0;
    fp_rd_i        = '0;
    fp_result_i    = '0;
    fflags_i       = '0;
  endtask

  // The memory stage hands over the plain unsigned product
  task automatic set_operands(input logic [31:0] a, input logic [31:0] b);
    rs1_data_i = a;
    rs2_data_i = b;
    product_i  = {32'd0, a} * {32'd0, b};
  endtask

  task automatic load_random();
    logic [31:0] rnd;
    rnd            = $urandom();
    instr_valid_i  = 1'b1;
    res_src_i      = rnd[2:0];
    funct3_i       = rnd[5:3];
    trap_i         = rnd[6];
    trap_code_i    = rnd[8:7];
    is_ebreak_i    = rnd[9];
    reg_write_i    = rnd[10];
    is_fp_load_i   = rnd[11];
    fp_reg_write_i = rnd[12];
    fp_rd_i        = rnd[17:13];
    fflags_i       = rnd[22:18];
    instr_i        = $urandom();
    alu_result_i   = $urandom();
    ld_data_i      = $urandom();
    pc_plus4_i     = $urandom();
    jb_tgt_i       = $urandom();
    csr_rdata_i    = $urandom();
    div_result_i   = $urandom();
    fp_result_i    = $urandom();
    set_operands($urandom(), $urandom());
  endtask

  task automatic check_record(input string name, input logic [31:0] exp_rd);
    compare(name, "ret_valid_o", 32'd1, 32'(ret_valid_o));
    compare(name, "ret_instr_o", instr_i, ret_instr_o);
    compare(name, "ret_pc_o", pc_plus4_i - 32'd4, ret_pc_o);
    compare(name, "ret_rs1_data_o", rs1_data_i, ret_rs1_data_o);
    compare(name, "ret_rs2_data_o", rs2_data_i, ret_rs2_data_o);
    compare(name, "ret_rd_data_o", exp_rd, ret_rd_data_o);
    compare(name, "ret_trap_o", 32'(trap_i), 32'(ret_trap_o));
    compare(name, "ret_trap_code_o", 32'(trap_code_i), 32'(ret_trap_code_o));
    compare(name, "ret_reg_write_o", 32'(reg_write_i), 32'(ret_reg_write_o));
    compare(name, "ret_ebreak_o", 32'(is_ebreak_i), 32'(ret_ebreak_o));
  endtask

  task automatic check_zero_record(input string name);
    compare(name, "ret_valid_o", 32'd0, 32'(ret_valid_o));
    compare(name, "ret_instr_o", 32'd0, ret_instr_o);
    compare(name, "ret_pc_o", 32'd0, ret_pc_o);
    compare(name, "ret_rs1_data_o", 32'd0, ret_rs1_data_o);
    compare(name, "ret_rs2_data_o", 32'd0, ret_rs2_data_o);
    compare(name, "ret_rd_data_o", 32'd0, ret_rd_data_o);
    compare(name, "ret_trap_o", 32'd0, 32'(ret_trap_o));
    compare(name, "ret_trap_code_o", 32'd0, 32'(ret_trap_code_o));
    compare(name, "ret_reg_write_o", 32'd0, 32'(ret_reg_write_o));
    compare(name, "ret_ebreak_o", 32'd0, 32'(ret_ebreak_o));
  endtask

  // Starts on a falling edge with inputs driven and returns on the next one
  task automatic retire_one(input string name);
    logic [31:0] exp_rd;
    exp_rd = expected_rd();
    #1;
    compare(name, "rd_data_o", exp_rd, rd_data_o);
    @(posedge clk);
    @(negedge clk);
    check_record(name, exp_rd);
  endtask

  task automatic reset_values();
    #1;
    check_zero_record("reset_values");
    @(posedge clk);
    @(negedge clk);
    check_zero_record("reset_values");
    finish_test("reset_values");
  endtask

  task automatic result_mux();
    for (int code = 0; code < 8; code++) begin
      load_random();
      res_src_i = code[2:0];
      retire_one("result_mux");
    end
    finish_test("result_mux");
  endtask

  task automatic m_extension();
    logic [31:0] edge_vals [5];
    edge_vals = '{32'h0000_0000, 32'h0000_0003, 32'hffff_ffff, 32'h8000_0000, 32'h7fff_ffff};
    for (int op = 0; op < 4; op++) begin
      for (int i = 0; i < 5; i++) begin
        for (int j = 0; j < 5; j++) begin
          load_random();
          res_src_i = RES_MEXT;
          funct3_i  = op[2:0];
          set_operands(edge_vals[i], edge_vals[j]);
          retire_one("m_extension");
        end
      end
      for (int k = 0; k < 8; k++) begin
        load_random();
        res_src_i = RES_MEXT;
        funct3_i  = op[2:0];
        retire_one("m_extension");
      end
    end
    // Divide and remainder codes
    for (int op = 4; op < 8; op++) begin
      load_random();
      res_src_i = RES_MEXT;
      funct3_i  = op[2:0];
      retire_one("m_extension");
    end
    finish_test("m_extension");
  endtask

  // Bit 0 picks load, bit 1 enables the write, bit 2 raises a flag
  task automatic fp_writeback();
    for (int i = 0; i < 8; i++) begin
      load_random();
      is_fp_load_i   = i[0];
      fp_reg_write_i = i[1];
      fflags_i       = i[2] ? (fflags_i | 5'd1) : 5'd0;
      #1;
      compare("fp_writeback", "fp_rd_data_o", i[0] ? ld_data_i : fp_result_i,
              fp_rd_data_o);
      compare("fp_writeback", "fp_rd_addr_o", 32'(fp_rd_i), 32'(fp_rd_addr_o));
      compare("fp_writeback", "fp_rd_en_o", 32'(i[1]), 32'(fp_rd_en_o));
      compare("fp_writeback", "fflags_set_o", 32'(fflags_i), 32'(fflags_set_o));
      compare("fp_writeback", "fflags_set_en_o", 32'(i[1] & i[2]), 32'(fflags_set_en_o));
      @(posedge clk);
      @(negedge clk);
    end
    finish_test("fp_writeback");
  endtask

  task automatic stall_and_bubbles();
    logic [31:0] saved_instr;
    logic [31:0] saved_pc;
    logic [31:0] saved_rd;
    load_random();
    res_src_i = RES_ALU;
    retire_one("stall_and_bubbles");
    saved_instr = instr_i;
    saved_pc    = pc_plus4_i - 32'd4;
    saved_rd    = alu_result_i;
    // Inputs keep changing while the register must hold
    stall_i = 1'b1;
    for (int k = 0; k < 4; k++) begin
      load_random();
      @(posedge clk);
      @(negedge clk);
      compare("stall_and_bubbles", "ret_valid_o", 32'd1, 32'(ret_valid_o));
      compare("stall_and_bubbles", "ret_instr_o", saved_instr, ret_instr_o);
      compare("stall_and_bubbles", "ret_pc_o", saved_pc, ret_pc_o);
      compare("stall_and_bubbles", "ret_rd_data_o", saved_rd, ret_rd_data_o);
    end
    stall_i = 1'b0;
    load_random();
    instr_valid_i = 1'b0;
    @(posedge clk);
    @(negedge clk);
    check_zero_record("stall_and_bubbles");
    // Back-to-back instructions retire on consecutive cycles
    load_random();
    retire_one("stall_and_bubbles");
    load_random();
    retire_one("stall_and_bubbles");
    finish_test("stall_and_bubbles");
  endtask

  task automatic record_fields();
    for (int i = 0; i < 8; i++) begin
      load_random();
      res_src_i = 3'(i % 6);
      if (i == 7) begin
        trap_i      = 1'b1;
        trap_code_i = 2'd3;
        is_ebreak_i = 1'b1;
        reg_write_i = 1'b0;
        pc_plus4_i  = 32'd2;
      end
      retire_one("record_fields");
    end
    finish_test("record_fields");
  endtask

  initial begin
    seed_init    = $urandom(9846);
    test_errors  = 0;
    tests_passed = 0;
    tests_failed = 0;
    drive_idle();
    arst_n_i = 1'b0;
    repeat (16) @(posedge clk);
    @(negedge clk);
    arst_n_i = 1'b1;
    reset_values();
    result_mux();
    m_extension();
    fp_writeback();
    stall_and_bubbles();
    record_fields();
    $display("Summary: %0d passed, %0d failed", tests_passed, tests_failed);
    if (tests_failed == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  initial begin
    #(NUM_TESTS * 200 * CLK_PERIOD);
    $display("Watchdog: the run did not finish within its time limit");
    $display("TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- logic/mul_sign_fix.sv
`timescale 1ns/10ps
`default_nettype none

`include "wb_consts.svh"

module mul_sign_fix
  import wb_pkg::*;
(
  input  logic [`WB_PROD_W-1:0] product_i,
  input  logic [`WB_XLEN-1:0]   rs1_data_i,
  input  logic [`WB_XLEN-1:0]   rs2_data_i,
  input  m_op_e                 op_i,
  output logic [`WB_XLEN-1:0]   result_o
);

  logic [`WB_XLEN-1:0] prod_lo;
  logic [`WB_XLEN-1:0] prod_hi;
  logic [`WB_XLEN-1:0] rs1_fix;
  logic [`WB_XLEN-1:0] rs2_fix;

  assign prod_lo = product_i[`WB_XLEN-1:0];
  assign prod_hi = product_i[`WB_PROD_W-1:`WB_XLEN];

  // A negative operand read as unsigned adds 2^XLEN times the other operand
  // to the product, so the high word loses that operand once
  always_comb begin
    rs1_fix  = '0;
    rs2_fix  = '0;
    result_o = prod_lo;
    case (op_i)
      MULH: begin
        rs1_fix  = rs1_data_i[`WB_XLEN-1] ? rs2_data_i : '0;
        rs2_fix  = rs2_data_i[`WB_XLEN-1] ? rs1_data_i : '0;
        result_o = prod_hi - rs1_fix - rs2_fix;
      end
      MULHSU: begin
        // rs2 is unsigned here
        rs1_fix  = rs1_data_i[`WB_XLEN-1] ? rs2_data_i : '0;
        result_o = prod_hi - rs1_fix;
      end
      MULHU:   result_o = prod_hi;
      default: result_o = prod_lo;
    endcase
  end

endmodule

`default_nettype wire

//--- logic/result_select.sv
`timescale 1ns/10ps
`default_nettype none

`include "wb_consts.svh"

module result_select
  import wb_pkg::*;
(
  wb_if.wb                          wb_i,
  input  logic [`WB_XLEN-1:0]       mul_result_i,
  output logic [`WB_XLEN-1:0]       rd_data_o,
  output logic [`WB_XLEN-1:0]       fp_rd_data_o,
  output logic [`WB_REG_ADDR_W-1:0] fp_rd_addr_o,
  output logic                      fp_rd_en_o,
  output logic [`WB_FFLAGS_W-1:0]   fflags_set_o,
  output logic                      fflags_set_en_o
);

  logic [`WB_XLEN-1:0] m_ext_result;

  // Divide finishes in the memory stage, multiply finishes here
  assign m_ext_result = wb_i.funct3[2] ? wb_i.div_result : mul_result_i;

  // Integer result for the register file
  always_comb begin
    case (wb_i.res_src)
      RES_ALU:   rd_data_o = wb_i.alu_result;
      RES_LOAD:  rd_data_o = wb_i.ld_data;
      RES_PC4:   rd_data_o = wb_i.pc_plus4;
      RES_JBTGT: rd_data_o = wb_i.jb_tgt;
      RES_CSR:   rd_data_o = wb_i.csr_rdata;
      RES_MEXT:  rd_data_o = m_ext_result;
      // Codes 6 and 7
      default:   rd_data_o = '0;
    endcase
  end

  // FLW writes load data, FP compute writes its own result
  assign fp_rd_data_o = wb_i.is_fp_load ? wb_i.ld_data : wb_i.fp_result;
  assign fp_rd_addr_o = wb_i.fp_rd;
  assign fp_rd_en_o   = wb_i.fp_reg_write;

  // Flags are accumulated into fcsr only when something was raised
  assign fflags_set_o    = wb_i.fflags;
  assign fflags_set_en_o = wb_i.fp_reg_write && (|wb_i.fflags);

endmodule

`default_nettype wire

//--- logic/retire_reg.sv
`timescale 1ns/10ps
`default_nettype none

`include "wb_consts.svh"

module retire_reg
  import wb_pkg::*;
(
  input  logic    clk,
  input  logic    arst_n_i,
  input  logic    stall_i,
  input  logic    valid_i,
  input  retire_t rec_i,
  output retire_t rec_o
);

  retire_t rec_q;
  logic    advance;
  logic    bubble;

  // Stall holds the record, an empty slot retires as zero
  assign advance = !stall_i;
  assign bubble  = !valid_i;

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rec_q <= '0;
    end else if (advance) begin
      if (bubble) begin
        rec_q <= '0;
      end else begin
        rec_q <= rec_i;
      end
    end
  end

  assign rec_o = rec_q;

endmodule

`default_nettype wire

//--- logic/wb_consts.svh
`ifndef WB_CONSTS_SVH
`define WB_CONSTS_SVH

// Integer data width, one word
`define WB_XLEN 32

// Unsigned multiply product, two words
`define WB_PROD_W 64

// Integer result source select
`define WB_RES_SEL_W 3

// Floating-point exception flags (NV, DZ, OF, UF, NX)
`define WB_FFLAGS_W 5

// Register index
`define WB_REG_ADDR_W 5

// Instruction word, funct3 field and trap cause
`define WB_INSTR_W 32
`define WB_FUNCT3_W 3
`define WB_TRAP_W 2

`endif

//--- logic/wb_if.sv
`timescale 1ns/10ps
`default_nettype none

`include "wb_consts.svh"

interface wb_if
  import wb_pkg::*;
();

  logic                      instr_valid;
  res_src_e                  res_src;
  logic [`WB_INSTR_W-1:0]    instr;
  logic [`WB_XLEN-1:0]       alu_result;
  logic [`WB_XLEN-1:0]       ld_data;
  logic [`WB_XLEN-1:0]       pc_plus4;
  logic [`WB_XLEN-1:0]       jb_tgt;
  logic [`WB_XLEN-1:0]       csr_rdata;
  logic [`WB_XLEN-1:0]       div_result;
  logic [`WB_FUNCT3_W-1:0]   funct3;
  logic [`WB_XLEN-1:0]       rs1_data;
  logic [`WB_XLEN-1:0]       rs2_data;
  logic [`WB_PROD_W-1:0]     product;
  logic                      trap;
  trap_code_t                trap_code;
  logic                      is_ebreak;
  logic                      reg_write;

  // Floating-point side
  logic                      is_fp_load;
  logic                      fp_reg_write;
  logic [`WB_REG_ADDR_W-1:0] fp_rd;
  logic [`WB_XLEN-1:0]       fp_result;
  logic [`WB_FFLAGS_W-1:0]   fflags;

  // Memory stage side
  modport mem (
    output instr_valid, res_src, instr, alu_result, ld_data, pc_plus4, jb_tgt,
    output csr_rdata, div_result, funct3, rs1_data, rs2_data, product, trap,
    output trap_code, is_ebreak, reg_write, is_fp_load, fp_reg_write, fp_rd,
    output fp_result, fflags
  );

  // Write-back stage side
  modport wb (
    input instr_valid, res_src, instr, alu_result, ld_data, pc_plus4, jb_tgt,
    input csr_rdata, div_result, funct3, rs1_data, rs2_data, product, trap,
    input trap_code, is_ebreak, reg_write, is_fp_load, fp_reg_write, fp_rd,
    input fp_result, fflags
  );

endinterface

`default_nettype wire

//--- logic/wb_pkg.sv
`default_nettype none

`include "wb_consts.svh"

package wb_pkg;

  // Integer result source, codes 6 and 7 select zero
  typedef enum logic [`WB_RES_SEL_W-1:0] {
    RES_ALU   = 3'd0,
    RES_LOAD  = 3'd1,
    RES_PC4   = 3'd2,
    RES_JBTGT = 3'd3,
    RES_CSR   = 3'd4,
    RES_MEXT  = 3'd5
  } res_src_e;

  // M extension operation, encoded as funct3
  // Bit 2 set marks a divide or remainder
  typedef enum logic [`WB_FUNCT3_W-1:0] {
    MUL    = 3'd0,
    MULH   = 3'd1,
    MULHSU = 3'd2,
    MULHU  = 3'd3,
    DIV    = 3'd4,
    DIVU   = 3'd5,
    REM    = 3'd6,
    REMU   = 3'd7
  } m_op_e;

  typedef logic [`WB_TRAP_W-1:0] trap_code_t;

  // One retired instruction
  typedef struct packed {
    logic                    valid;
    logic [`WB_INSTR_W-1:0]  instr;
    logic [`WB_XLEN-1:0]     pc;
    logic [`WB_XLEN-1:0]     rs1_data;
    logic [`WB_XLEN-1:0]     rs2_data;
    logic [`WB_XLEN-1:0]     rd_data;
    logic                    trap;
    trap_code_t              trap_code;
    logic                    reg_write;
    logic                    ebreak;
  } retire_t;

endpackage

`default_nettype wire

//--- logic/wb_stage.sv
`timescale 1ns/10ps
`default_nettype none

`include "wb_consts.svh"

module wb_stage
  import wb_pkg::*;
(
  input  logic                      clk,
  input  logic                      arst_n_i,
  input  logic                      stall_i,
  wb_if.wb                          wb_i,
  output logic [`WB_XLEN-1:0]       rd_data_o,
  output logic [`WB_XLEN-1:0]       fp_rd_data_o,
  output logic [`WB_REG_ADDR_W-1:0] fp_rd_addr_o,
  output logic                      fp_rd_en_o,
  output logic [`WB_FFLAGS_W-1:0]   fflags_set_o,
  output logic                      fflags_set_en_o,
  output retire_t                   ret_o
);

  localparam logic [`WB_XLEN-1:0] INSTR_BYTES = 4;

  logic [`WB_XLEN-1:0] mul_result;
  logic [`WB_XLEN-1:0] pc;
  retire_t             rec;

  // Sign correction of the unsigned product from the memory stage
  mul_sign_fix u_mul_sign_fix (
    .product_i  (wb_i.product),
    .rs1_data_i (wb_i.rs1_data),
    .rs2_data_i (wb_i.rs2_data),
    .op_i       (m_op_e'(wb_i.funct3)),
    .result_o   (mul_result)
  );

  result_select u_result_select (
    .wb_i            (wb_i),
    .mul_result_i    (mul_result),
    .rd_data_o       (rd_data_o),
    .fp_rd_data_o    (fp_rd_data_o),
    .fp_rd_addr_o    (fp_rd_addr_o),
    .fp_rd_en_o      (fp_rd_en_o),
    .fflags_set_o    (fflags_set_o),
    .fflags_set_en_o (fflags_set_en_o)
  );

  // Only pc+4 travels this far down the pipe
  assign pc = wb_i.pc_plus4 - INSTR_BYTES;

  assign rec = '{
    valid:     wb_i.instr_valid,
    instr:     wb_i.instr,
    pc:        pc,
    rs1_data:  wb_i.rs1_data,
    rs2_data:  wb_i.rs2_data,
    rd_data:   rd_data_o,
    trap:      wb_i.trap,
    trap_code: wb_i.trap_code,
    reg_write: wb_i.reg_write,
    ebreak:    wb_i.is_ebreak
  };

  retire_reg u_retire_reg (
    .clk      (clk),
    .arst_n_i (arst_n_i),
    .stall_i  (stall_i),
    .valid_i  (wb_i.instr_valid),
    .rec_i    (rec),
    .rec_o    (ret_o)
  );

endmodule

`default_nettype wire

//--- logic/wb_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "wb_consts.svh"

module wb_top
  import wb_pkg::*;
(
  input  logic                      clk,
  input  logic                      arst_n_i,
  input  logic                      stall_i,

  // From the memory stage
  input  logic                      instr_valid_i,
  input  logic [`WB_RES_SEL_W-1:0]  res_src_i,
  input  logic [`WB_INSTR_W-1:0]    instr_i,
  input  logic [`WB_XLEN-1:0]       alu_result_i,
  input  logic [`WB_XLEN-1:0]       ld_data_i,
  input  logic [`WB_XLEN-1:0]       pc_plus4_i,
  input  logic [`WB_XLEN-1:0]       jb_tgt_i,
  input  logic [`WB_XLEN-1:0]       csr_rdata_i,
  input  logic [`WB_XLEN-1:0]       div_result_i,
  input  logic [`WB_FUNCT3_W-1:0]   funct3_i,
  input  logic [`WB_XLEN-1:0]       rs1_data_i,
  input  logic [`WB_XLEN-1:0]       rs2_data_i,
  input  logic [`WB_PROD_W-1:0]     product_i,
  input  logic                      trap_i,
  input  logic [`WB_TRAP_W-1:0]     trap_code_i,
  input  logic                      is_ebreak_i,
  input  logic                      reg_write_i,
  input  logic                      is_fp_load_i,
  input  logic                      fp_reg_write_i,
  input  logic [`WB_REG_ADDR_W-1:0] fp_rd_i,
  input  logic [`WB_XLEN-1:0]       fp_result_i,
  input  logic [`WB_FFLAGS_W-1:0]   fflags_i,

  // Same-cycle register file writes
  output logic [`WB_XLEN-1:0]       rd_data_o,
  output logic [`WB_XLEN-1:0]       fp_rd_data_o,
  output logic [`WB_REG_ADDR_W-1:0] fp_rd_addr_o,
  output logic                      fp_rd_en_o,
  output logic [`WB_FFLAGS_W-1:0]   fflags_set_o,
  output logic                      fflags_set_en_o,

  // Retirement, one cycle after the edge
  output logic                      ret_valid_o,
  output logic [`WB_INSTR_W-1:0]    ret_instr_o,
  output logic [`WB_XLEN-1:0]       ret_pc_o,
  output logic [`WB_XLEN-1:0]       ret_rs1_data_o,
  output logic [`WB_XLEN-1:0]       ret_rs2_data_o,
  output logic [`WB_XLEN-1:0]       ret_rd_data_o,
  output logic                      ret_trap_o,
  output logic [`WB_TRAP_W-1:0]     ret_trap_code_o,
  output logic                      ret_reg_write_o,
  output logic                      ret_ebreak_o
);

  wb_if    wb_bus ();
  retire_t ret;

  assign wb_bus.instr_valid  = instr_valid_i;
  assign wb_bus.res_src      = res_src_e'(res_src_i);
  assign wb_bus.instr        = instr_i;
  assign wb_bus.alu_result   = alu_result_i;
  assign wb_bus.ld_data      = ld_data_i;
  assign wb_bus.pc_plus4     = pc_plus4_i;
  assign wb_bus.jb_tgt       = jb_tgt_i;
  assign wb_bus.csr_rdata    = csr_rdata_i;
  assign wb_bus.div_result   = div_result_i;
  assign wb_bus.funct3       = funct3_i;
  assign wb_bus.rs1_data     = rs1_data_i;
  assign wb_bus.rs2_data     = rs2_data_i;
  assign wb_bus.product      = product_i;
  assign wb_bus.trap         = trap_i;
  assign wb_bus.trap_code    = trap_code_i;
  assign wb_bus.is_ebreak    = is_ebreak_i;
  assign wb_bus.reg_write    = reg_write_i;
  assign wb_bus.is_fp_load   = is_fp_load_i;
  assign wb_bus.fp_reg_write = fp_reg_write_i;
  assign wb_bus.fp_rd        = fp_rd_i;
  assign wb_bus.fp_result    = fp_result_i;
  assign wb_bus.fflags       = fflags_i;

  wb_stage u_wb_stage (
    .clk             (clk),
    .arst_n_i        (arst_n_i),
    .stall_i         (stall_i),
    .wb_i            (wb_bus.wb),
    .rd_data_o       (rd_data_o),
    .fp_rd_data_o    (fp_rd_data_o),
    .fp_rd_addr_o    (fp_rd_addr_o),
    .fp_rd_en_o      (fp_rd_en_o),
    .fflags_set_o    (fflags_set_o),
    .fflags_set_en_o (fflags_set_en_o),
    .ret_o           (ret)
  );

  assign ret_valid_o     = ret.valid;
  assign ret_instr_o     = ret.instr;
  assign ret_pc_o        = ret.pc;
  assign ret_rs1_data_o  = ret.rs1_data;
  assign ret_rs2_data_o  = ret.rs2_data;
  assign ret_rd_data_o   = ret.rd_data;
  assign ret_trap_o      = ret.trap;
  assign ret_trap_code_o = ret.trap_code;
  assign ret_reg_write_o = ret.reg_write;
  assign ret_ebreak_o    = ret.ebreak;

endmodule

`default_nettype wire

//--- sources.f
+incdir+logic
logic/wb_pkg.sv
logic/wb_if.sv
logic/mul_sign_fix.sv
logic/result_select.sv
logic/retire_reg.sv
logic/wb_stage.sv
logic/wb_top.sv
bench/wb_tb.sv
